/* vlog.f */
+incdir+.
flitPkg.sv
arbPkg.sv
portIf.sv
holdTimer.sv
portArbiter.sv
switchCrossbar.sv
routerOutputPort.sv
tbClock.sv
routerOutputPortTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module routerOutputPortTb -o simv
./obj_dir/simv

/* routerOutputPortTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

module routerOutputPortTb;
  import flitPkg::*;
  import arbPkg::*;

  logic      clk;
  logic      rst;
  portMask_t req;
  flitId_t   fid [`NUM_PORTS];
  pktLen_t   len [`NUM_PORTS];
  flitData_t data [`NUM_PORTS];
  portMask_t grant;
  flitData_t outData;
  logic      outValid;

  integer    seed;
  int        refState; // -1 is idle, else the granted port.
  int        nextRef;
  pktLen_t   refLimit [`NUM_PORTS];
  pktLen_t   refCount [`NUM_PORTS];
  portMask_t tu;
  portMask_t expGrant;
  flitData_t expData;
  logic      expValid;

  tbClock uClock (.clk(clk), .rst(rst));

  routerOutputPort uut (
    .clk(clk), .rst(rst), .req(req),
    .lFlitId(fid[0]), .lLength(len[0]), .lData(data[0]),
    .nFlitId(fid[1]), .nLength(len[1]), .nData(data[1]),
    .eFlitId(fid[2]), .eLength(len[2]), .eData(data[2]),
    .wFlitId(fid[3]), .wLength(len[3]), .wData(data[3]),
    .sFlitId(fid[4]), .sLength(len[4]), .sData(data[4]),
    .grant(grant), .outData(outData), .outValid(outValid)
  );

  task automatic failText(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic failValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  // ------------------------------
  // reference arbiter, rotating priority with hold limit.
  function automatic int refNextState(input int cur, input portMask_t r, input portMask_t up);
    int nxt;
    int first;
    int span;
    int k;

    nxt = -1;
    if (cur >= 0 && r[cur] && !up[cur])
      nxt = cur;
    else
    begin
      first = (cur < 0) ? 0 : cur + 1;
      span  = (cur < 0) ? `NUM_PORTS : `NUM_PORTS - 1; // the holder is not checked again.
      for (int off = 0; off < span; off++)
      begin
        k = (first + off) % `NUM_PORTS;
        if (nxt < 0 && r[k])
          nxt = k;
      end
    end
    return nxt;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      refState = -1;
      expValid = 1'b0;
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        refLimit[i] = '0;
        refCount[i] = '0;
      end
    end
    else
    begin
      expValid = (refState >= 0);
      if (refState >= 0)
        expData = data[refState]; // registered one cycle behind the grant.
      for (int i = 0; i < `NUM_PORTS; i++)
        tu[i] = (refCount[i] == refLimit[i]);
      nextRef = refNextState(refState, req, tu);
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        if (i == refState && nextRef == refState)
          refCount[i] = refCount[i] + pktLen_t'(1);
        else
          refCount[i] = '0;
        if (fid[i] == FLIT_HEADER)
          refLimit[i] = len[i];
      end
      refState = nextRef;
    end
    expGrant = '0;
    if (refState >= 0)
      expGrant = portMask_t'(1) << refState;
  end

  // outputs are stable at the falling edge.
  always @(negedge clk)
  begin
    if (!rst)
    begin
      assert (grant === expGrant)
        else failValue("grant", 32'(grant), 32'(expGrant));
      assert (outValid === expValid)
        else failValue("outValid", 32'(outValid), 32'(expValid));
      if (expValid)
        assert (outData === expData)
          else failValue("outData", outData, expData);
    end
  end

  // ------------------------------
  task automatic stepClock;
    @(posedge clk);
    #1;
    for (int i = 0; i < `NUM_PORTS; i++)
      data[i] = $random(seed);
  endtask

  task automatic bodyFlits;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      fid[i] = flitId_t'(2);
      len[i] = pktLen_t'(9); // must not touch the limit.
    end
  endtask

  task automatic waitGrant(input portMask_t mask);
    int n;

    n = 0;
    while (grant !== mask && n < 50)
    begin
      stepClock;
      n++;
    end
    assert (grant === mask) else failText("grant did not reach the expected port in time");
  endtask

  task automatic measureHold(input portMask_t mask, input int cycles);
    int n;

    waitGrant(mask);
    n = 0;
    while (grant === mask && n < 64)
    begin
      n++;
      stepClock;
    end
    assert (n < 64) else failText("the holding port never released the grant");
    assert (n == cycles) else failValue("holdCycles", 32'(n), 32'(cycles));
  endtask

  initial
  begin
    int n;

    seed = 32'h9c8d;
    req  = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      fid[i]  = '0;
      len[i]  = '0;
      data[i] = '0;
    end
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (rst && n < 100);
    assert (!rst) else failText("reset was never released");

    for (n = 0; n < 4; n++)
      stepClock;
    assert (grant == '0 && !outValid) else failText("grant or valid active without requests");

    // header lengths L 3, N 2, E 1, W 4, S 0.
    fid = '{FLIT_HEADER, FLIT_HEADER, FLIT_HEADER, FLIT_HEADER, FLIT_HEADER};
    len = '{pktLen_t'(3), pktLen_t'(2), pktLen_t'(1), pktLen_t'(4), pktLen_t'(0)};
    stepClock;
    bodyFlits;
    req = 5'b01110;
    measureHold(5'b00010, 3);
    measureHold(5'b00100, 2);
    measureHold(5'b01000, 5); // West timer.
    measureHold(5'b00010, 3);

    // ------------------------------
    req    = '0;
    fid[0] = FLIT_HEADER;
    len[0] = pktLen_t'(6);
    fid[4] = FLIT_HEADER;
    len[4] = pktLen_t'(6);
    stepClock;
    bodyFlits;
    waitGrant('0);
    req = 5'b10000;
    waitGrant(5'b10000);
    req = 5'b10001;
    stepClock;
    stepClock;
    assert (grant === 5'b10000) else failValue("grant", 32'(grant), 32'h10);
    req = 5'b00001; // S drops, wraps to L.
    waitGrant(5'b00001);

    // long random traffic, requests high about 3 of 4 cycles.
    for (n = 0; n < 3000; n++)
    begin
      req = portMask_t'($random(seed) | $random(seed));
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        fid[i] = (($random(seed) & 3) == 0) ? FLIT_HEADER : flitId_t'(2);
        len[i] = pktLen_t'({$random(seed)} % 7);
      end
      stepClock;
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period.
  end

  initial
  begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* routerOutputPort.sv */
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

module routerOutputPort (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  flitPkg::flitId_t      lFlitId,
  input  flitPkg::pktLen_t      lLength,
  input  flitPkg::flitData_t    lData,
  input  flitPkg::flitId_t      nFlitId,
  input  flitPkg::pktLen_t      nLength,
  input  flitPkg::flitData_t    nData,
  input  flitPkg::flitId_t      eFlitId,
  input  flitPkg::pktLen_t      eLength,
  input  flitPkg::flitData_t    eData,
  input  flitPkg::flitId_t      wFlitId,
  input  flitPkg::pktLen_t      wLength,
  input  flitPkg::flitData_t    wData,
  input  flitPkg::flitId_t      sFlitId,
  input  flitPkg::pktLen_t      sLength,
  input  flitPkg::flitData_t    sData,
  output arbPkg::portMask_t     grant,
  output flitPkg::flitData_t    outData,
  output logic                  outValid
);

  portIf ports [`NUM_PORTS] ();

  // ------------------------------
  // index order L, N, E, W, S.
  assign ports[0].req    = req[0];
  assign ports[0].flitId = lFlitId;
  assign ports[0].length = lLength;
  assign ports[0].data   = lData;

  assign ports[1].req    = req[1];
  assign ports[1].flitId = nFlitId;
  assign ports[1].length = nLength;
  assign ports[1].data   = nData;

  assign ports[2].req    = req[2];
  assign ports[2].flitId = eFlitId;
  assign ports[2].length = eLength;
  assign ports[2].data   = eData;

  assign ports[3].req    = req[3];
  assign ports[3].flitId = wFlitId;
  assign ports[3].length = wLength;
  assign ports[3].data   = wData;

  assign ports[4].req    = req[4];
  assign ports[4].flitId = sFlitId;
  assign ports[4].length = sLength;
  assign ports[4].data   = sData;

  portArbiter uArbiter (
    .clk   (clk),
    .rst   (rst),
    .ports (ports),
    .grant (grant)
  );

  switchCrossbar uCrossbar (
    .clk      (clk),
    .rst      (rst),
    .ports    (ports),
    .grant    (grant),
    .outData  (outData),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

/* switchCrossbar.sv */
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

module switchCrossbar (
  input  logic               clk,
  input  logic               rst,
  portIf.crossbar            ports [`NUM_PORTS],
  input  arbPkg::portMask_t  grant,
  output flitPkg::flitData_t outData,
  output logic               outValid
);
  import flitPkg::*;

  flitData_t portData [`NUM_PORTS];
  flitData_t selData;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gData
    assign portData[i] = ports[i].data;
  end

  // and-or select, grant is one-hot.
  always_comb
  begin
    selData = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i])
        selData = selData | portData[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |grant;
  end

  always_ff @(posedge clk)
  begin
    outData <= selData; // one cycle behind the grant.
  end

  // each granted port's data shows up one cycle later.
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gCheck
    assert property (@(posedge clk) disable iff (rst)
      $past(grant[i]) |-> (outValid && (outData == $past(portData[i]))))
      else $error("switchCrossbar output does not follow the granted port");
  end

endmodule

`default_nettype wire

/* portArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "router_params.svh"

module portArbiter (
  input  logic              clk,
  input  logic              rst,
  portIf.arbiter            ports [`NUM_PORTS],
  output arbPkg::portMask_t grant
);
  import arbPkg::*;

  arbState_t state;
  arbState_t nextState;
  portIdx_t  holder;
  portMask_t req;
  portMask_t timesUp;
  portMask_t runTimer;

  // ------------------------------
  // per-port request and hold timer.
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gPort
    assign req[i] = ports[i].req;

    holdTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (ports[i].flitId),
      .length   (ports[i].length),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  // ------------------------------
  // rotating priority.
  assign holder = portIdx_t'(state) - portIdx_t'(1); // port index of the current state.

  always_comb
  begin
    int cand;

    cand      = 0;
    nextState = ARB_IDLE;
    runTimer  = '0;
    if (state == ARB_IDLE)
    begin
      // scanned from S down so L ends up on top.
      for (int i = `NUM_PORTS - 1; i >= 0; i--)
      begin
        if (req[i])
          nextState = arbState_t'(i + 1);
      end
    end
    else if (req[holder] && !timesUp[holder])
    begin
      nextState        = state;
      runTimer[holder] = 1'b1; // count only while the grant is kept.
    end
    else
    begin
      // nearest requester after the holder wins, the holder is skipped.
      for (int off = `NUM_PORTS - 1; off >= 1; off--)
      begin
        cand = (int'(holder) + off) % `NUM_PORTS;
        if (req[cand])
          nextState = arbState_t'(cand + 1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

  assign grant = (state == ARB_IDLE) ? '0 : (portMask_t'(1) << holder);

  // ------------------------------
  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("portArbiter grant is not one-hot");

  // a grant always answers a request seen one cycle earlier.
  assert property (@(posedge clk) disable iff (rst) (grant & ~$past(req)) == '0)
    else $error("portArbiter granted a port without a request");

endmodule

`default_nettype wire

/* holdTimer.sv */
`timescale 1ns/10ps
`default_nettype none

module holdTimer (
  input  logic             clk,
  input  logic             rst,
  input  flitPkg::flitId_t flitId,
  input  flitPkg::pktLen_t length,
  input  logic             runTimer,
  output logic             timesUp
);
  import flitPkg::*;

  pktLen_t limit;
  pktLen_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == FLIT_HEADER)
        limit <= length; // reloads whether or not the port is granted.
      if (runTimer)
        count <= count + pktLen_t'(1);
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

  // the arbiter stops the run at the limit, so the count can only
  // pass it when a new header lowered the limit mid-run.
  assert property (@(posedge clk) disable iff (rst)
    (runTimer && (count <= limit)) |=> ((count <= limit) || (limit != $past(limit))))
    else $error("holdTimer count passed its limit");

endmodule

`default_nettype wire

/* portIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface portIf;
  import flitPkg::*;

  logic      req;    // level, held while the port wants the output.
  flitId_t   flitId;
  pktLen_t   length;
  flitData_t data;

  // ------------------------------
  modport arbiter (
    input req,
    input flitId,
    input length
  );

  modport crossbar (
    input data
  );

endinterface

`default_nettype wire

/* arbPkg.sv */
`default_nettype none

`include "router_params.svh"

package arbPkg;

  typedef logic [`NUM_PORTS-1:0]         portMask_t; // bit 0 is L, bit 4 is S.
  typedef logic [$clog2(`NUM_PORTS)-1:0] portIdx_t;

  // one state per port plus idle.
  typedef enum logic [2:0] {
    ARB_IDLE = 3'd0,
    ARB_L    = 3'd1,
    ARB_N    = 3'd2,
    ARB_E    = 3'd3,
    ARB_W    = 3'd4,
    ARB_S    = 3'd5
  } arbState_t;

endpackage

`default_nettype wire

/* flitPkg.sv */
`default_nettype none

`include "router_params.svh"

package flitPkg;

  typedef logic [`FLIT_DATA_W-1:0] flitData_t;
  typedef logic [`FLIT_ID_W-1:0]   flitId_t;
  typedef logic [`PKT_LEN_W-1:0]   pktLen_t;

  localparam flitId_t FLIT_HEADER = flitId_t'(1); // marks the first flit of a packet.

endpackage

`default_nettype wire

/* router_params.svh */
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// flit field widths.
`define FLIT_DATA_W 32
`define FLIT_ID_W   3
`define PKT_LEN_W   12 // also the hold limit width.

// input ports L, N, E, W, S.
`define NUM_PORTS   5

`endif
